// File: Makefile
TOP = lsu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f lsu.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f lsu.f

clean:
	rm -rf obj_dir

// File: dv/lsu_asserts.sv
module lsu_asserts (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [lsu_pkg::num_banks-1:0] ram_ce,
  input  logic                          done,
  input  lsu_pkg::beat_t                out_data,
  input  logic                          out_valid,
  input  logic                          out_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  int fails = 0;

  // one bank per cycle
  ce_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ram_ce))
    else begin
      $error("more than one ram_ce bit set");
      fails++;
    end

  done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      $error("done high for more than one cycle");
      fails++;
    end

  // stalled output beat must hold
  out_hold: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> $stable(out_data))
    else begin
      $error("out_data changed while stalled");
      fails++;
    end

endmodule

// File: dv/lsu_tb.sv
module lsu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import lsu_pkg::*;

  localparam int timeout_cycles = 4000;
  localparam int mem_words      = 2 ** addr_w;

  logic           clk = 1'b0;
  logic           rst;
  beat_t          in_data;
  logic           in_valid;
  logic           in_ready;
  beat_t          out_data;
  logic           out_valid;
  logic           out_ready;
  logic           start;
  logic           store;
  logic           done;
  cfg_t           len;
  cfg_t           seg_count;
  cfg_t           block_factor;
  cfg_t           seg_stride;
  cfg_t           addr_offset;
  addr_t          ram_addr;
  word_t          ram_d;
  logic           ram_we;
  logic [num_banks-1:0] ram_ce;
  word_t          ram_q [num_banks];

  word_t       bank_mem [num_banks][mem_words];
  word_t       ref_mem [num_banks][mem_words];
  word_t       rd_pipe [rd_latency][num_banks] = '{default: '0};
  word_t       sent_q [$];
  int          errors = 0;
  int          mon_errors = 0;
  int          tests = 0;
  int          wr_cnt = 0;
  int          wr_base = 0;
  int          done_cnt = 0;
  int          transfers = 0;
  logic        quiet = 1'b1;
  logic        store_active = 1'b0;
  logic        timed_out = 1'b0;
  logic [31:0] lcg_state = 32'h0db8b8c6;
  string       name;
  string       dir;
  int          t_len;
  int          t_segs;
  int          t_bf;
  int          t_stride;
  int          t_off;
  int          t_beats;
  int          t_mode;

  always #5 clk = ~clk;

  lsu_top i_dut (.*);

  bind lsu_top lsu_asserts i_asserts (
    .clk       (clk),
    .rst       (rst),
    .ram_ce    (ram_ce),
    .done      (done),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t fill_word(input int b, input int a);
    return {32'hc0de0000 | 32'(b), 20'h0, 12'(a)};
  endfunction

  function automatic int bank_of(input int j);
    return (j / t_bf) % num_banks;
  endfunction

  function automatic int addr_of(input int s, input int j);
    return (t_off + s * t_stride + (j / (num_banks * t_bf)) * t_bf + j % t_bf) % mem_words;
  endfunction

  // bank model with read data rd_latency cycles after the chip enable
  assign ram_q = rd_pipe[rd_latency-1];

  always @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < num_banks; b++) begin
        for (int a = 0; a < mem_words; a++) begin
          bank_mem[b][a] <= fill_word(b, a);
        end
      end
    end else begin
      for (int b = 0; b < num_banks; b++) begin
        if (ram_ce[b] && ram_we) begin
          bank_mem[b][ram_addr] <= ram_d;
        end
        rd_pipe[0][b] <= (ram_ce[b] && !ram_we) ? bank_mem[b][ram_addr] : '0;
      end
      for (int i = 1; i < rd_latency; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
      if (ram_we && ram_ce != '0) begin
        wr_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (done) begin
        done_cnt++;
      end
      assert (!quiet || ram_ce == '0) else begin
        $display("ram_ce active after done at %0t", $time);
        mon_errors++;
      end
      assert (store_active || !in_ready) else begin
        $display("in_ready high with no store running at %0t", $time);
        mon_errors++;
      end
    end
  end

  task automatic check_done_count();
    assert (done_cnt == transfers) else begin
      $display("ERR %s done pulses exp %0d act %0d", name, transfers, done_cnt);
      errors++;
    end
  endtask

  task automatic start_transfer(input logic is_store);
    @(negedge clk);
    check_done_count();
    len          = cfg_t'(t_len);
    seg_count    = cfg_t'(t_segs);
    block_factor = cfg_t'(t_bf);
    seg_stride   = cfg_t'(t_stride);
    addr_offset  = cfg_t'(t_off);
    store        = is_store;
    start        = 1'b1;
    quiet        = 1'b0;
    store_active = is_store;
    wr_base      = wr_cnt;
    transfers++;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_done();
    int n = 0;
    while (!done) begin
      if (n == timeout_cycles) begin
        $display("timeout waiting for done in test %s", name);
        errors++;
        timed_out = 1'b1;
        return;
      end
      n++;
      @(negedge clk);
    end
    quiet        = 1'b1;
    store_active = 1'b0;
  endtask

  task automatic send_store();
    beat_t beat;
    int    gap;
    int    n;
    for (int k = 0; k < t_beats; k++) begin
      for (int w = 0; w < words_per_beat; w++) begin
        beat[w*word_w +: word_w] = {rand32(), rand32()};
        sent_q.push_back(beat[w*word_w +: word_w]);
      end
      // long enough gaps outlast the unpacker and leave in_ready waiting
      gap = (t_mode != 0) ? int'(rand32() >> 28) : 0;
      for (int g = 0; g < gap; g++) begin
        @(negedge clk);
      end
      in_data  = beat;
      in_valid = 1'b1;
      n = 0;
      while (!in_ready) begin
        if (n == timeout_cycles) begin
          $display("timeout waiting for in_ready in test %s", name);
          errors++;
          timed_out = 1'b1;
          in_valid  = 1'b0;
          return;
        end
        n++;
        @(negedge clk);
      end
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  // expected bank contents after a store follow the placement rule
  task automatic update_ref();
    for (int k = 0; k < sent_q.size(); k++) begin
      ref_mem[bank_of(k % t_len)][addr_of(k / t_len, k % t_len)] = sent_q[k];
    end
  endtask

  task automatic check_store();
    assert (wr_cnt - wr_base == t_beats * words_per_beat) else begin
      $display("ERR %s writes exp %0d act %0d", name, t_beats * words_per_beat,
               wr_cnt - wr_base);
      errors++;
    end
    for (int b = 0; b < num_banks; b++) begin
      for (int a = 0; a < mem_words; a++) begin
        assert (bank_mem[b][a] === ref_mem[b][a]) else begin
          $display("ERR %s bank %0d addr %03h exp %h act %h", name, b, a,
                   ref_mem[b][a], bank_mem[b][a]);
          errors++;
        end
      end
    end
  endtask

  task automatic recv_load();
    beat_t exp;
    int    got = 0;
    int    n = 0;
    int    k;
    while (got < t_beats) begin
      if (n == timeout_cycles) begin
        $display("timeout waiting for output beat %0d in test %s", got, name);
        errors++;
        timed_out = 1'b1;
        return;
      end
      n++;
      // sink slower than the beat rate, so the FIFO fills and issue must wait
      out_ready = (t_mode != 0) ? (rand32() < 32'h10000000) : 1'b1;
      if (out_valid && out_ready) begin
        for (int w = 0; w < words_per_beat; w++) begin
          k = got * words_per_beat + w;
          exp[w*word_w +: word_w] = ref_mem[bank_of(k % t_len)][addr_of(k / t_len, k % t_len)];
        end
        assert (out_data === exp) else begin
          $display("ERR %s beat %0d exp %h act %h", name, got, exp, out_data);
          errors++;
        end
        got++;
      end
      @(negedge clk);
    end
  endtask

  initial begin
    int    fd;
    int    nf;
    string line;
    rst          = 1'b1;
    in_data      = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b0;
    start        = 1'b0;
    store        = 1'b0;
    len          = '0;
    seg_count    = '0;
    block_factor = '0;
    seg_stride   = '0;
    addr_offset  = '0;
    name         = "reset";
    for (int b = 0; b < num_banks; b++) begin
      for (int a = 0; a < mem_words; a++) begin
        ref_mem[b][a] = fill_word(b, a);
      end
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;

    fd = $fopen("dv/lsu_tests.txt", "r");
    assert (fd != 0) else begin
      $display("cannot open dv/lsu_tests.txt");
      errors++;
    end
    while (fd != 0 && !timed_out && !$feof(fd)) begin
      if ($fgets(line, fd) == 0) begin
        break;
      end
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      nf = $sscanf(line, "%s %s %d %d %d %d %d %d %d", name, dir, t_len, t_segs, t_bf,
                   t_stride, t_off, t_beats, t_mode);
      if (nf != 9) begin
        $display("malformed test line: %s", line);
        errors++;
        continue;
      end
      tests++;
      if (dir == "s") begin
        sent_q.delete();
        start_transfer(1'b1);
        send_store();
        update_ref();
        if (!timed_out) begin
          wait_done();
        end
        if (!timed_out) begin
          check_store();
        end
      end else begin
        start_transfer(1'b0);
        recv_load();
        if (!timed_out) begin
          wait_done();
        end
        // fifo must be empty once the load reports done
        if (!timed_out) begin
          assert (!out_valid) else begin
            $display("extra output beat after done in test %s", name);
            errors++;
          end
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    @(negedge clk);
    check_done_count();
    errors = errors + mon_errors + i_dut.i_asserts.fails;
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: dv/lsu_tests.txt
# name dir len seg_count block_factor seg_stride addr_offset beats mode
# dir s is a store, l a load; mode 1 adds in_valid gaps (store) or out_ready stalls (load)
st_bf1 s 16 3 1 64 0 6 0
ld_bf1 l 16 3 1 64 0 6 0
st_bf2 s 24 2 2 40 200 6 0
ld_bf2 l 24 2 2 40 200 6 1
st_bf3 s 20 4 3 32 500 10 0
ld_bf3 l 20 4 3 32 500 10 1
st_gap s 20 4 3 32 500 10 1
ld_gap l 20 4 3 32 500 10 0
st_one s 8 1 1 0 3000 1 1
ld_one l 8 1 1 0 3000 1 1

// File: logic/lsu_addr_gen.sv
module lsu_addr_gen (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           busy_store,
  input  logic                           busy_load,
  input  logic                           issue_ok,
  input  lsu_pkg::word_t                 word_data,
  input  logic                           word_valid,
  input  lsu_pkg::cfg_t                  len,
  input  lsu_pkg::cfg_t                  seg_count,
  input  lsu_pkg::cfg_t                  block_factor,
  input  lsu_pkg::cfg_t                  seg_stride,
  input  lsu_pkg::cfg_t                  addr_offset,
  output logic                           word_ready,
  output lsu_pkg::addr_t                 ram_addr,
  output lsu_pkg::word_t                 ram_d,
  output logic                           ram_we,
  output logic [lsu_pkg::num_banks-1:0]  ram_ce,
  output lsu_pkg::bank_t                 rd_bank,
  output logic                           rd_issue,
  output logic                           last_issued
);
  import lsu_pkg::*;

  cfg_t  word_cnt;
  cfg_t  seg_cnt;
  cfg_t  blk_cnt;
  cfg_t  row_base;
  cfg_t  seg_base;
  bank_t bank_cnt;
  cfg_t  cur_addr;
  logic  issue;
  logic  seg_end;
  logic  blk_end;

  // stores issue straight off the word handshake, one per cycle
  assign word_ready = busy_store;
  assign issue      = (busy_store & word_valid) | (busy_load & issue_ok);

  assign seg_end     = (word_cnt == len - 1'b1);
  assign blk_end     = (blk_cnt == block_factor - 1'b1);
  assign last_issued = issue & seg_end & (seg_cnt == seg_count - 1'b1);

  // offset + s*seg_stride + (j div 4bf)*bf + (j mod bf)
  assign cur_addr = addr_offset + seg_base + row_base + blk_cnt;

  always_ff @(posedge clk) begin
    if (rst | ~(busy_store | busy_load)) begin
      word_cnt <= '0;
      seg_cnt  <= '0;
      blk_cnt  <= '0;
      row_base <= '0;
      seg_base <= '0;
      bank_cnt <= '0;
    end else if (issue) begin
      if (seg_end) begin
        word_cnt <= '0;
        blk_cnt  <= '0;
        row_base <= '0;
        bank_cnt <= '0;
        seg_cnt  <= seg_cnt + 1'b1;
        seg_base <= seg_base + seg_stride;
      end else begin
        word_cnt <= word_cnt + 1'b1;
        if (blk_end) begin
          blk_cnt <= '0;
          if (bank_cnt == bank_t'(num_banks - 1)) begin
            bank_cnt <= '0;
            row_base <= row_base + block_factor;
          end else begin
            bank_cnt <= bank_cnt + 1'b1;
          end
        end else begin
          blk_cnt <= blk_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ram_we   <= 1'b0;
      ram_ce   <= '0;
      rd_issue <= 1'b0;
    end else begin
      ram_we   <= issue & busy_store;
      ram_ce   <= issue ? (num_banks'(1) << bank_cnt) : '0;
      rd_issue <= issue & busy_load;
    end
  end

  always_ff @(posedge clk) begin
    ram_addr <= cur_addr[addr_w-1:0];
    ram_d    <= word_data;
    rd_bank  <= bank_cnt;
  end

endmodule

// File: logic/lsu_beat_fifo.sv
module lsu_beat_fifo (
  input  logic           clk,
  input  logic           rst,
  input  lsu_pkg::beat_t enq_data,
  input  logic           enq_valid,
  input  logic           deq_ready,
  output lsu_pkg::beat_t deq_data,
  output logic           deq_valid,
  output logic [1:0]     free
);
  import lsu_pkg::*;

  typedef logic [$clog2(fifo_depth)-1:0] ptr_t;

  beat_t      mem [fifo_depth];
  ptr_t       wr_ptr;
  ptr_t       rd_ptr;
  logic [1:0] count;
  logic       deq_fire;

  function automatic ptr_t next_ptr(input ptr_t p);
    return (p == ptr_t'(fifo_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign deq_valid = (count != '0);
  assign deq_data  = mem[rd_ptr];
  assign deq_fire  = deq_valid & deq_ready;
  assign free      = 2'(fifo_depth) - count;

  // no full check, the read credits keep a slot open for every push
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (deq_fire) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + 2'(enq_valid) - 2'(deq_fire);
    end
  end

  always_ff @(posedge clk) begin
    if (enq_valid) begin
      mem[wr_ptr] <= enq_data;
    end
  end

endmodule

// File: logic/lsu_beat_pack.sv
module lsu_beat_pack (
  input  logic           clk,
  input  logic           rst,
  input  logic           rd_issue,
  input  lsu_pkg::bank_t rd_bank,
  input  lsu_pkg::word_t ram_q [lsu_pkg::num_banks],
  output lsu_pkg::beat_t beat_data,
  output logic           beat_pushed
);
  import lsu_pkg::*;

  logic [rd_latency-1:0]             vld_pipe;
  bank_t                             bank_pipe [rd_latency];
  logic [$clog2(words_per_beat)-1:0] fill_cnt;
  logic                              ret_valid;
  bank_t                             ret_bank;
  word_t                             ret_word;

  // read returns line up with the tail of the delay line
  assign ret_valid = vld_pipe[rd_latency-1];
  assign ret_bank  = bank_pipe[rd_latency-1];
  assign ret_word  = ram_q[ret_bank];

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe    <= '0;
      fill_cnt    <= '0;
      beat_pushed <= 1'b0;
    end else begin
      vld_pipe    <= {vld_pipe[rd_latency-2:0], rd_issue};
      beat_pushed <= ret_valid & (fill_cnt == ($bits(fill_cnt))'(words_per_beat - 1));
      if (ret_valid) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    bank_pipe[0] <= rd_bank;
    for (int i = 1; i < rd_latency; i++) begin
      bank_pipe[i] <= bank_pipe[i-1];
    end
    if (ret_valid) begin
      beat_data[fill_cnt*word_w +: word_w] <= ret_word;
    end
  end

endmodule

// File: logic/lsu_beat_unpack.sv
module lsu_beat_unpack (
  input  logic           clk,
  input  logic           rst,
  input  logic           busy_store,
  input  lsu_pkg::beat_t in_data,
  input  logic           in_valid,
  input  logic           word_ready,
  output logic           in_ready,
  output lsu_pkg::word_t word_data,
  output logic           word_valid
);
  import lsu_pkg::*;

  beat_t                               shift_q;
  logic [$clog2(words_per_beat+1)-1:0] left;
  logic                                in_fire;
  logic                                word_fire;

  assign in_ready   = busy_store & (left == '0);
  assign word_valid = (left != '0);
  assign word_data  = shift_q[word_w-1:0];

  assign in_fire   = in_valid & in_ready;
  assign word_fire = word_valid & word_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      left <= '0;
    end else if (in_fire) begin
      left <= ($bits(left))'(words_per_beat);
    end else if (word_fire) begin
      left <= left - 1'b1;
    end
  end

  // low word goes out first
  always_ff @(posedge clk) begin
    if (in_fire) begin
      shift_q <= in_data;
    end else if (word_fire) begin
      shift_q <= shift_q >> word_w;
    end
  end

endmodule

// File: logic/lsu_ctrl.sv
module lsu_ctrl (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic       store,
  input  logic       last_issued,
  input  logic       beat_popped,
  input  logic       beat_pushed,
  input  logic [1:0] fifo_free,
  output logic       busy_store,
  output logic       busy_load,
  output logic       issue_ok,
  output logic       done
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_drain,
    st_done
  } state_t;

  state_t                            state;
  logic                              is_store;
  logic [$clog2(words_per_beat)-1:0] word_cnt;
  logic [1:0]                        in_flight;
  logic                              grant;
  logic                              last_pop;

  assign busy_store = (state == st_run) & is_store;
  assign busy_load  = (state == st_run) & ~is_store;

  // first word of a beat claims a FIFO slot, the other seven ride on that claim
  assign issue_ok = busy_load & ((word_cnt != '0) | (in_flight < fifo_free));
  assign grant    = issue_ok & (word_cnt == '0);

  // nothing in flight and only one beat left in the FIFO, leaving now
  assign last_pop = beat_popped & (in_flight == '0) & (fifo_free == 2'(fifo_depth - 1));

  assign done = (state == st_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      is_store  <= 1'b0;
      word_cnt  <= '0;
      in_flight <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state    <= st_run;
            is_store <= store;
          end
        end
        st_run: begin
          if (last_issued) begin
            state <= st_drain;
          end
        end
        // store only waits for the last write to reach the ports
        st_drain: begin
          if (is_store | last_pop) begin
            state <= st_done;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase

      if (issue_ok) begin
        word_cnt <= word_cnt + 1'b1;
      end
      in_flight <= in_flight + 2'(grant) - 2'(beat_pushed);
    end
  end

endmodule

// File: logic/lsu_pkg.sv
package lsu_pkg;

  localparam int word_w         = 64;
  localparam int beat_w         = 512;
  localparam int words_per_beat = beat_w / word_w;

  // group size, also the cyclic factor of the placement
  localparam int num_banks      = 4;
  localparam int addr_w         = 12;

  // chip enable at the ports to valid ram_q
  localparam int rd_latency     = 4;
  localparam int fifo_depth     = 2;
  localparam int cfg_w          = 16;

  typedef logic [word_w-1:0]            word_t;
  typedef logic [beat_w-1:0]            beat_t;
  typedef logic [addr_w-1:0]            addr_t;
  typedef logic [$clog2(num_banks)-1:0] bank_t;
  typedef logic [cfg_w-1:0]             cfg_t;

endpackage

// File: logic/lsu_top.sv
module lsu_top (
  input  logic                          clk,
  input  logic                          rst,
  input  lsu_pkg::beat_t                in_data,
  input  logic                          in_valid,
  output logic                          in_ready,
  output lsu_pkg::beat_t                out_data,
  output logic                          out_valid,
  input  logic                          out_ready,
  input  logic                          start,
  input  logic                          store,
  output logic                          done,
  input  lsu_pkg::cfg_t                 len,
  input  lsu_pkg::cfg_t                 seg_count,
  input  lsu_pkg::cfg_t                 block_factor,
  input  lsu_pkg::cfg_t                 seg_stride,
  input  lsu_pkg::cfg_t                 addr_offset,
  output lsu_pkg::addr_t                ram_addr,
  output lsu_pkg::word_t                ram_d,
  output logic                          ram_we,
  output logic [lsu_pkg::num_banks-1:0] ram_ce,
  input  lsu_pkg::word_t                ram_q [lsu_pkg::num_banks]
);
  import lsu_pkg::*;

  logic       busy_store;
  logic       busy_load;
  logic       issue_ok;
  logic       last_issued;
  word_t      word_data;
  logic       word_valid;
  logic       word_ready;
  bank_t      rd_bank;
  logic       rd_issue;
  beat_t      beat_data;
  logic       beat_pushed;
  logic       beat_popped;
  logic [1:0] fifo_free;

  assign beat_popped = out_valid & out_ready;

  lsu_ctrl i_ctrl (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .store       (store),
    .last_issued (last_issued),
    .beat_popped (beat_popped),
    .beat_pushed (beat_pushed),
    .fifo_free   (fifo_free),
    .busy_store  (busy_store),
    .busy_load   (busy_load),
    .issue_ok    (issue_ok),
    .done        (done)
  );

  lsu_beat_unpack i_unpack (
    .clk        (clk),
    .rst        (rst),
    .busy_store (busy_store),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .word_ready (word_ready),
    .in_ready   (in_ready),
    .word_data  (word_data),
    .word_valid (word_valid)
  );

  lsu_addr_gen i_addr_gen (
    .clk          (clk),
    .rst          (rst),
    .busy_store   (busy_store),
    .busy_load    (busy_load),
    .issue_ok     (issue_ok),
    .word_data    (word_data),
    .word_valid   (word_valid),
    .len          (len),
    .seg_count    (seg_count),
    .block_factor (block_factor),
    .seg_stride   (seg_stride),
    .addr_offset  (addr_offset),
    .word_ready   (word_ready),
    .ram_addr     (ram_addr),
    .ram_d        (ram_d),
    .ram_we       (ram_we),
    .ram_ce       (ram_ce),
    .rd_bank      (rd_bank),
    .rd_issue     (rd_issue),
    .last_issued  (last_issued)
  );

  lsu_beat_pack i_pack (
    .clk         (clk),
    .rst         (rst),
    .rd_issue    (rd_issue),
    .rd_bank     (rd_bank),
    .ram_q       (ram_q),
    .beat_data   (beat_data),
    .beat_pushed (beat_pushed)
  );

  lsu_beat_fifo i_fifo (
    .clk       (clk),
    .rst       (rst),
    .enq_data  (beat_data),
    .enq_valid (beat_pushed),
    .deq_ready (out_ready),
    .deq_data  (out_data),
    .deq_valid (out_valid),
    .free      (fifo_free)
  );

endmodule

// File: lsu.f
logic/lsu_pkg.sv
logic/lsu_ctrl.sv
logic/lsu_addr_gen.sv
logic/lsu_beat_unpack.sv
logic/lsu_beat_pack.sv
logic/lsu_beat_fifo.sv
logic/lsu_top.sv
dv/lsu_asserts.sv
dv/lsu_tb.sv
